/* flist.f */
src/lbp_cfg_pkg.sv
src/lbp_types_pkg.sv
src/lbp_ctrl.sv
src/lbp_history_table.sv
src/lbp_pattern_table.sv
src/lbp_top.sv
verif/lbp_tb.sv

/* run.sh */
#!/bin/sh
# Build the predictor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lbp_tb -f flist.f -o lbp_sim || exit 1

out=$(./obj_dir/lbp_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* src/lbp_cfg_pkg.sv */
// Local branch predictor geometry
// Sizes of the per-slot history and pattern tables and the PC bit
// fields used to index them
`default_nettype none

package lbp_cfg_pkg;

  // Virtual address width
  localparam int unsigned VLEN = 32;

  // Instruction slots per fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;

  // Bit 0 is dropped since compressed instructions are 2-byte aligned
  localparam int unsigned PC_OFFSET = 1;

  // PC bits that pick the slot inside the fetch block
  localparam int unsigned SLOT_BITS = 1;

  // Local history table, rows per slot
  localparam int unsigned NR_ROWS_LHR  = 16;
  localparam int unsigned LHR_IDX_BITS = 4;

  // First PC bit of the history row index
  localparam int unsigned LHR_IDX_LSB = PC_OFFSET + SLOT_BITS;

  // Pattern table, rows per slot, addressed by the local history
  localparam int unsigned NR_ROWS_PHT = 16;
  localparam int unsigned HIST_BITS   = 4;

  // Saturating counters
  localparam int unsigned             CTR_BITS  = 2;
  localparam logic [CTR_BITS-1:0]     CTR_RESET = 2'b10;
  localparam logic [CTR_BITS-1:0]     CTR_MAX   = {CTR_BITS{1'b1}};

endpackage

`default_nettype wire

/* src/lbp_ctrl.sv */
// Local branch predictor control
// Qualifies execute updates, decodes the target slot and history row,
// and sweeps both tables one row per cycle on a flush request. Issues
// the write commands for the history and pattern tables.
`timescale 1ns/1ps
`default_nettype none

module lbp_ctrl
  import lbp_cfg_pkg::*;
  import lbp_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        debug_mode_i,
  input  lbp_update_t update_i,
  output lhr_wr_t     lhr_wr_o,
  output pht_wr_t     pht_wr_o,
  output logic        busy_o
);

  lbp_state_e              state_q, state_d;
  logic [LHR_IDX_BITS-1:0] sweep_row_q, sweep_row_d;
  logic                    sweep_last;

  logic                    upd_accept;
  logic [SLOT_BITS-1:0]    upd_slot;
  logic [LHR_IDX_BITS-1:0] upd_row;

  // ----------------------------------------------------------------------
  // Update decode
  // ----------------------------------------------------------------------

  assign upd_slot   = update_i.pc[PC_OFFSET +: SLOT_BITS];
  assign upd_row    = update_i.pc[LHR_IDX_LSB +: LHR_IDX_BITS];
  // Debug mode freezes the predictor
  assign upd_accept = update_i.valid && !debug_mode_i;

  assign sweep_last = (sweep_row_q == LHR_IDX_BITS'(NR_ROWS_LHR - 1));
  assign busy_o     = (state_q == LBP_FLUSH);

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------

  always_comb begin : next_state
    state_d     = state_q;
    sweep_row_d = sweep_row_q;
    unique case (state_q)
      LBP_IDLE: begin
        if (flush_i) begin
          state_d     = LBP_FLUSH;
          sweep_row_d = '0;
        end
      end
      LBP_FLUSH: begin
        // A new flush request here has no effect
        sweep_row_d = sweep_row_q + LHR_IDX_BITS'(1);
        if (sweep_last) begin
          state_d = LBP_IDLE;
        end
      end
      default: begin
        state_d = LBP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= LBP_IDLE;
      sweep_row_q <= '0;
    end else begin
      state_q     <= state_d;
      sweep_row_q <= sweep_row_d;
    end
  end

  // ----------------------------------------------------------------------
  // Table write commands
  // ----------------------------------------------------------------------

  always_comb begin : write_cmd
    lhr_wr_o = '0;
    pht_wr_o = '0;
    if (state_q == LBP_FLUSH) begin
      // Clear the current sweep row in every slot
      lhr_wr_o.we    = '1;
      lhr_wr_o.addr  = sweep_row_q;
      lhr_wr_o.clear = 1'b1;
      pht_wr_o.en    = '1;
      pht_wr_o.addr  = HIST_BITS'(sweep_row_q);
      pht_wr_o.clear = 1'b1;
    end else if (upd_accept) begin
      for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
        lhr_wr_o.we[i] = (upd_slot == SLOT_BITS'(i));
        pht_wr_o.en[i] = (upd_slot == SLOT_BITS'(i));
      end
      lhr_wr_o.addr  = upd_row;
      lhr_wr_o.taken = update_i.taken;
      // Counter address is the history seen at lookup
      pht_wr_o.addr  = update_i.meta.hist;
      pht_wr_o.taken = update_i.taken;
    end
  end

endmodule

`default_nettype wire

/* src/lbp_history_table.sv */
// Local history table
// One history word per row and slot. The lookup port reads the row
// picked by the fetch PC, the update port reads the written row so the
// outcome can be shifted in.
`timescale 1ns/1ps
`default_nettype none

module lbp_history_table
  import lbp_cfg_pkg::*;
  import lbp_types_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [VLEN-1:0]                           vpc_i,
  input  lhr_wr_t                                   lhr_wr_i,
  output logic [INSTR_PER_FETCH-1:0][HIST_BITS-1:0] hist_o
);

  logic [HIST_BITS-1:0] lhr_q [INSTR_PER_FETCH][NR_ROWS_LHR];

  logic [LHR_IDX_BITS-1:0]                   lookup_row;
  logic [INSTR_PER_FETCH-1:0][HIST_BITS-1:0] upd_hist;
  logic [INSTR_PER_FETCH-1:0][HIST_BITS-1:0] upd_hist_next;

  assign lookup_row = vpc_i[LHR_IDX_LSB +: LHR_IDX_BITS];

  // ----------------------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_read
    // Both slots of a fetch block share the row index
    assign hist_o[i]   = lhr_q[i][lookup_row];
    assign upd_hist[i] = lhr_q[i][lhr_wr_i.addr];
  end

  // ----------------------------------------------------------------------
  // Write data
  // ----------------------------------------------------------------------

  always_comb begin : shift_in
    for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
      if (lhr_wr_i.clear) begin
        upd_hist_next[i] = '0;
      end else begin
        // Newest outcome enters at the LSB, oldest drops out
        upd_hist_next[i] = {upd_hist[i][HIST_BITS-2:0], lhr_wr_i.taken};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
        for (int unsigned r = 0; r < NR_ROWS_LHR; r++) begin
          lhr_q[i][r] <= '0;
        end
      end
    end else begin
      for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
        if (lhr_wr_i.we[i]) begin
          lhr_q[i][lhr_wr_i.addr] <= upd_hist_next[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/lbp_pattern_table.sv */
// Pattern table of 2-bit saturating counters
// Each slot is addressed by its local history. Lookup returns the
// entry's valid bit and the counter MSB as the taken prediction, with
// the history as metadata. Updates step the counter read-modify-write.
`timescale 1ns/1ps
`default_nettype none

module lbp_pattern_table
  import lbp_cfg_pkg::*;
  import lbp_types_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [INSTR_PER_FETCH-1:0][HIST_BITS-1:0] hist_i,
  input  pht_wr_t                                   pht_wr_i,
  output lbp_pred_t [INSTR_PER_FETCH-1:0]           pred_o
);

  typedef struct packed {
    logic                valid;
    logic [CTR_BITS-1:0] ctr;
  } pht_entry_t;

  pht_entry_t pht_q [INSTR_PER_FETCH][NR_ROWS_PHT];

  pht_entry_t [INSTR_PER_FETCH-1:0] upd_entry;
  pht_entry_t [INSTR_PER_FETCH-1:0] upd_entry_next;

  // One counter step, held at both ends
  function automatic logic [CTR_BITS-1:0] ctr_step(
    input logic [CTR_BITS-1:0] ctr,
    input logic                taken
  );
    logic [CTR_BITS-1:0] res;
    res = ctr;
    if (taken) begin
      if (ctr != CTR_MAX) begin
        res = ctr + CTR_BITS'(1);
      end
    end else begin
      if (ctr != '0) begin
        res = ctr - CTR_BITS'(1);
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // Lookup and prediction
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_pred
    pht_entry_t lookup_entry;

    assign lookup_entry        = pht_q[i][hist_i[i]];
    assign pred_o[i].valid     = lookup_entry.valid;
    assign pred_o[i].taken     = lookup_entry.ctr[CTR_BITS-1];
    assign pred_o[i].meta.hist = hist_i[i];
  end

  // ----------------------------------------------------------------------
  // Update
  // ----------------------------------------------------------------------

  always_comb begin : counter_update
    for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
      upd_entry[i] = pht_q[i][pht_wr_i.addr];
      if (pht_wr_i.clear) begin
        upd_entry_next[i].valid = 1'b0;
        upd_entry_next[i].ctr   = CTR_RESET;
      end else begin
        upd_entry_next[i].valid = 1'b1;
        upd_entry_next[i].ctr   = ctr_step(upd_entry[i].ctr, pht_wr_i.taken);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Counters start weakly taken with no valid entry
      for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
        for (int unsigned r = 0; r < NR_ROWS_PHT; r++) begin
          pht_q[i][r].valid <= 1'b0;
          pht_q[i][r].ctr   <= CTR_RESET;
        end
      end
    end else begin
      for (int unsigned i = 0; i < INSTR_PER_FETCH; i++) begin
        if (pht_wr_i.en[i]) begin
          pht_q[i][pht_wr_i.addr] <= upd_entry_next[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/lbp_top.sv */
// Local two-level branch predictor
// Per-slot local history selects a 2-bit counter in the slot's pattern
// table. Lookup is combinational from the fetch PC; updates from execute
// land at the next edge. A flush sweeps both tables in 16 cycles.
`timescale 1ns/1ps
`default_nettype none

module lbp_top
  import lbp_cfg_pkg::*;
  import lbp_types_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            debug_mode_i,
  input  logic [VLEN-1:0]                 vpc_i,
  input  lbp_update_t                     update_i,
  output lbp_pred_t [INSTR_PER_FETCH-1:0] pred_o,
  output logic                            busy_o
);

  lhr_wr_t                                   lhr_wr;
  pht_wr_t                                   pht_wr;
  logic [INSTR_PER_FETCH-1:0][HIST_BITS-1:0] lookup_hist;

  lbp_ctrl i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .update_i     (update_i),
    .lhr_wr_o     (lhr_wr),
    .pht_wr_o     (pht_wr),
    .busy_o       (busy_o)
  );

  lbp_history_table i_lhr (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .vpc_i    (vpc_i),
    .lhr_wr_i (lhr_wr),
    .hist_o   (lookup_hist)
  );

  // History from the first level addresses the counters
  lbp_pattern_table i_pht (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .hist_i   (lookup_hist),
    .pht_wr_i (pht_wr),
    .pred_o   (pred_o)
  );

endmodule

`default_nettype wire

/* src/lbp_types_pkg.sv */
// Local branch predictor types
// Update and prediction records exchanged with fetch and execute,
// table write commands from the control block and the control states
`default_nettype none

package lbp_types_pkg;

  import lbp_cfg_pkg::*;

  // History that selected the counter at lookup time
  typedef struct packed {
    logic [HIST_BITS-1:0] hist;
  } lbp_meta_t;

  // Resolved branch from execute
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] pc;
    logic            taken;
    lbp_meta_t       meta;
  } lbp_update_t;

  // Per-slot prediction towards fetch
  typedef struct packed {
    logic      valid;
    logic      taken;
    lbp_meta_t meta;
  } lbp_pred_t;

  // History table write, shift-in or clear
  typedef struct packed {
    logic [INSTR_PER_FETCH-1:0] we;
    logic [LHR_IDX_BITS-1:0]    addr;
    logic                       taken;
    logic                       clear;
  } lhr_wr_t;

  // Pattern table write, counter step or clear
  typedef struct packed {
    logic [INSTR_PER_FETCH-1:0] en;
    logic [HIST_BITS-1:0]       addr;
    logic                       taken;
    logic                       clear;
  } pht_wr_t;

  typedef enum logic {
    LBP_IDLE,
    LBP_FLUSH
  } lbp_state_e;

endpackage

`default_nettype wire

/* verif/lbp_tb.sv */
// Testbench for the local two-level branch predictor
// Drives lookups, execute updates, debug mode and flushes, and checks
// every prediction and busy_o against a model of both tables
`timescale 1ns/1ps
`default_nettype none

module lbp_tb
  import lbp_cfg_pkg::*;
  import lbp_types_pkg::*;
();

  localparam logic [31:0] SEED            = 32'h797393f9;
  localparam int          RESET_CYCLES    = 8;
  localparam int          DIRECTED_CYCLES = 120;
  localparam int          RANDOM_CYCLES   = 400;
  localparam int          STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
  localparam int          TIMEOUT_CYCLES  = 2 * STIM_CYCLES + NR_ROWS_LHR;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            flush_i;
  logic                            debug_mode_i;
  logic [VLEN-1:0]                 vpc_i;
  lbp_update_t                     update_i;
  lbp_pred_t [INSTR_PER_FETCH-1:0] pred_o;
  logic                            busy_o;

  // Reference copy of the tables and the flush sweep
  logic [HIST_BITS-1:0] m_lhr [INSTR_PER_FETCH][NR_ROWS_LHR];
  logic [CTR_BITS-1:0]  m_ctr [INSTR_PER_FETCH][NR_ROWS_PHT];
  logic                 m_val [INSTR_PER_FETCH][NR_ROWS_PHT];
  logic                 m_busy;
  int                   m_row;
  int unsigned          cycle_cnt = 0;

  lbp_top i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .vpc_i        (vpc_i),
    .update_i     (update_i),
    .pred_o       (pred_o),
    .busy_o       (busy_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout expired after %0d cycles", cycle_cnt));
    end
  end

  // ----------------------------------------------------------------------
  // Checking
  // ----------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string what, input int slot, input int got, input int exp);
    assert (got == exp) else begin
      abort_run($sformatf("mismatch at time %0t: %s slot %0d got %0d expected %0d",
                          $time, what, slot, got, exp));
    end
  endtask

  // Lookup seen by the DUT compared with the model tables
  task automatic compare_all();
    int                   row;
    logic [HIST_BITS-1:0] h;
    row = int'(vpc_i[LHR_IDX_LSB +: LHR_IDX_BITS]);
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      h = m_lhr[s][row];
      check_eq("pred valid", s, int'(pred_o[s].valid), int'(m_val[s][h]));
      check_eq("pred taken", s, int'(pred_o[s].taken), int'(m_ctr[s][h][CTR_BITS-1]));
      check_eq("pred meta", s, int'(pred_o[s].meta.hist), int'(h));
    end
    check_eq("busy", 0, int'(busy_o), int'(m_busy));
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  task automatic clear_model();
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      for (int r = 0; r < NR_ROWS_LHR; r++) begin
        m_lhr[s][r] = '0;
        m_ctr[s][r] = CTR_RESET;
        m_val[s][r] = 1'b0;
      end
    end
    m_busy = 1'b0;
    m_row  = 0;
  endtask

  task automatic advance_model();
    int                   s;
    int                   r;
    int                   c;
    logic [HIST_BITS-1:0] h;
    if (m_busy) begin
      for (int k = 0; k < INSTR_PER_FETCH; k++) begin
        m_lhr[k][m_row] = '0;
        m_ctr[k][m_row] = CTR_RESET;
        m_val[k][m_row] = 1'b0;
      end
      if (m_row == NR_ROWS_LHR - 1) begin
        m_busy = 1'b0;
      end
      m_row = m_row + 1;
    end else begin
      if (update_i.valid && !debug_mode_i) begin
        s = int'(update_i.pc[PC_OFFSET +: SLOT_BITS]);
        r = int'(update_i.pc[LHR_IDX_LSB +: LHR_IDX_BITS]);
        h = update_i.meta.hist;
        m_lhr[s][r] = {m_lhr[s][r][HIST_BITS-2:0], update_i.taken};
        c = int'(m_ctr[s][h]) + (update_i.taken ? 1 : -1);
        if (c < 0) begin
          c = 0;
        end else if (c > int'(CTR_MAX)) begin
          c = int'(CTR_MAX);
        end
        m_ctr[s][h] = CTR_BITS'(c);
        m_val[s][h] = 1'b1;
      end
      if (flush_i) begin
        m_busy = 1'b1;
        m_row  = 0;
      end
    end
  endtask

  function automatic logic [HIST_BITS-1:0] predicted_hist(input logic [VLEN-1:0] pc);
    return m_lhr[int'(pc[PC_OFFSET +: SLOT_BITS])][int'(pc[LHR_IDX_LSB +: LHR_IDX_BITS])];
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  // Random upper and offset bits around a fixed slot and row
  function automatic logic [VLEN-1:0] make_pc(input int slot, input int row);
    logic [VLEN-1:0] pc;
    pc = $urandom();
    pc[PC_OFFSET +: SLOT_BITS]       = SLOT_BITS'(slot);
    pc[LHR_IDX_LSB +: LHR_IDX_BITS] = LHR_IDX_BITS'(row);
    return pc;
  endfunction

  function automatic logic [VLEN-1:0] rand_pc();
    return make_pc(int'($urandom_range(INSTR_PER_FETCH - 1, 0)),
                   int'($urandom_range(NR_ROWS_LHR - 1, 0)));
  endfunction

  task automatic drive_update(input logic valid, input logic [VLEN-1:0] pc, input logic taken,
                              input logic [HIST_BITS-1:0] hist);
    update_i.valid     = valid;
    update_i.pc        = pc;
    update_i.taken     = taken;
    update_i.meta.hist = hist;
  endtask

  // Check before the edge and advance the model after it
  task automatic step();
    @(negedge clk_i);
    compare_all();
    @(posedge clk_i);
    advance_model();
    #1;
  endtask

  task automatic sweep_lookups();
    for (int r = 0; r < NR_ROWS_LHR; r++) begin
      vpc_i = make_pc(0, r);
      step();
    end
  endtask

  task automatic expect_reset_state();
    drive_update(1'b0, '0, 1'b0, '0);
    for (int r = 0; r < NR_ROWS_LHR; r++) begin
      vpc_i = make_pc(0, r);
      #1;
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        check_eq("reset valid", s, int'(pred_o[s].valid), 0);
        check_eq("reset taken", s, int'(pred_o[s].taken), int'(CTR_RESET[CTR_BITS-1]));
        check_eq("reset meta", s, int'(pred_o[s].meta.hist), 0);
      end
      step();
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin : stimulus
    logic [VLEN-1:0] pc_a;
    logic [VLEN-1:0] pc_b;
    logic            outcomes [6];
    int              exp_ctr;
    int              busy_cnt;
    void'($urandom(SEED));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    debug_mode_i = 1'b0;
    vpc_i        = '0;
    update_i     = '0;
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    expect_reset_state();

    // Counter walk on slot 1 pattern row 0 seen through lookup row 0
    pc_a    = make_pc(1, 3);
    vpc_i   = make_pc(0, 0);
    exp_ctr = int'(CTR_RESET);
    for (int k = 0; k < 9; k++) begin
      drive_update(1'b1, pc_a, k < 4, '0);
      step();
      if (k < 4) begin
        exp_ctr = (exp_ctr < int'(CTR_MAX)) ? exp_ctr + 1 : exp_ctr;
      end else begin
        exp_ctr = (exp_ctr > 0) ? exp_ctr - 1 : exp_ctr;
      end
      check_eq("walk valid", 1, int'(pred_o[1].valid), 1);
      check_eq("walk taken", 1, int'(pred_o[1].taken), (exp_ctr >> (CTR_BITS - 1)) & 1);
    end

    // Local history holds the last four outcomes with the newest at the LSB
    outcomes = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    pc_b     = make_pc(0, 5);
    vpc_i    = pc_b;
    for (int k = 0; k < 6; k++) begin
      drive_update(1'b1, pc_b, outcomes[k], predicted_hist(pc_b));
      step();
    end
    drive_update(1'b0, '0, 1'b0, '0);
    check_eq("history", 0, int'(pred_o[0].meta.hist),
             int'({outcomes[2], outcomes[3], outcomes[4], outcomes[5]}));
    sweep_lookups();

    // Debug mode freezes both tables
    debug_mode_i = 1'b1;
    for (int k = 0; k < 8; k++) begin
      vpc_i = rand_pc();
      drive_update(1'b1, rand_pc(), 1'b1, HIST_BITS'($urandom()));
      step();
    end
    debug_mode_i = 1'b0;
    drive_update(1'b0, '0, 1'b0, '0);
    sweep_lookups();

    // Flush sweep with updates and a second request inside the window
    flush_i = 1'b1;
    step();
    busy_cnt = 0;
    while (busy_o) begin
      busy_cnt = busy_cnt + 1;
      flush_i  = (busy_cnt == 5);
      drive_update(1'b1, rand_pc(), 1'($urandom()), HIST_BITS'($urandom()));
      step();
    end
    flush_i = 1'b0;
    check_eq("busy cycles", 0, busy_cnt, NR_ROWS_LHR);
    expect_reset_state();

    // Random traffic that mostly carries the history a real lookup returns
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      vpc_i = rand_pc();
      pc_a  = rand_pc();
      drive_update($urandom_range(9, 0) < 6, pc_a, 1'($urandom()),
                   ($urandom_range(3, 0) == 0) ? HIST_BITS'($urandom()) : predicted_hist(pc_a));
      debug_mode_i = ($urandom_range(19, 0) == 0);
      flush_i      = ($urandom_range(49, 0) == 0);
      step();
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
